/* rtl/memPkg.sv */
package memPkg;

  // Bus widths
  localparam int addrWidth = 32;
  localparam int dataWidth = 32;
  localparam int strbWidth = dataWidth / 8;

  // Boot ROM window, 256 bytes
  localparam logic [addrWidth-1:0] romBase = 32'h0000_0000;
  localparam int romWords = 64;
  localparam int romIndexWidth = $clog2(romWords);
  localparam int romAddrLsb = romIndexWidth + 2;  // First address bit above the window

  // Scratch RAM window, 1 KiB
  localparam logic [addrWidth-1:0] ramBase = 32'h0001_0000;
  localparam int ramWords = 256;
  localparam int ramIndexWidth = $clog2(ramWords);
  localparam int ramAddrLsb = ramIndexWidth + 2;

  // Access kind seen on the bus
  typedef enum logic {
    opRead,
    opWrite
  } memOp_e;

  // Target picked by the address decoder
  typedef enum logic [1:0] {
    regionRom,
    regionRam,
    regionNone  // Unmapped, answered with an error
  } memRegion_e;

endpackage

/* rtl/bootRom.sv */
`timescale 1ns/1ps

module bootRom
  import memPkg::*;
(
  input  logic                     clock,
  input  logic                     arstN,
  input  logic                     romValid,
  input  logic [romIndexWidth-1:0] romIndex,
  output logic [dataWidth-1:0]     romRdata,
  output logic                     romReady
);

  logic [dataWidth-1:0] tableWord;

  // Startup program, upper words left blank
  always_comb begin
    case (romIndex)
      6'd0:    tableWord = 32'h41014081;
      6'd1:    tableWord = 32'h42014181;
      6'd2:    tableWord = 32'h43014281;
      6'd3:    tableWord = 32'h44014381;
      6'd4:    tableWord = 32'h45014481;
      6'd5:    tableWord = 32'h46014581;
      6'd6:    tableWord = 32'h47014681;
      6'd7:    tableWord = 32'h48014781;
      6'd8:    tableWord = 32'h49014881;
      6'd9:    tableWord = 32'h4A014981;
      6'd10:   tableWord = 32'h4B014A81;
      6'd11:   tableWord = 32'h4C014B81;
      6'd12:   tableWord = 32'h4D014C81;
      6'd13:   tableWord = 32'h4E014D81;
      6'd14:   tableWord = 32'h4F014E81;
      6'd15:   tableWord = 32'h62F94F81;
      6'd16:   tableWord = 32'h60028293;
      6'd17:   tableWord = 32'h3002A073;
      6'd18:   tableWord = 32'hA07342A1;
      6'd19:   tableWord = 32'h62853002;
      6'd20:   tableWord = 32'h80028293;
      6'd21:   tableWord = 32'h3042A073;
      6'd22:   tableWord = 32'h00000297;
      6'd23:   tableWord = 32'h01C28293;
      6'd24:   tableWord = 32'h30529073;
      6'd25:   tableWord = 32'h010002B7;
      6'd26:   tableWord = 32'h80000337;
      6'd27:   tableWord = 32'h0E374381;
      6'd28:   tableWord = 32'hA0010008;
      6'd29:   tableWord = 32'h800002B7;
      6'd30:   tableWord = 32'h237302E1;
      6'd31:   tableWord = 32'h9AE33420;
      6'd32:   tableWord = 32'h8E83FE62;
      6'd33:   tableWord = 32'h00230002;
      6'd34:   tableWord = 32'h030501D3;
      6'd35:   tableWord = 32'hD4630385;
      6'd36:   tableWord = 32'h007301C3;
      6'd37:   tableWord = 32'h00B73020;
      6'd38:   tableWord = 32'h80678000;  // Last program word
      default: tableWord = '0;
    endcase
  end

  // Word is captured every cycle, valid or not
  always_ff @(posedge clock) begin
    romRdata <= tableWord;
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      romReady <= 1'b0;
    end else begin
      romReady <= romValid;  // One cycle completion
    end
  end

endmodule

/* rtl/scratchRam.sv */
`timescale 1ns/1ps

module scratchRam
  import memPkg::*;
(
  input  logic                     clock,
  input  logic                     arstN,
  input  logic                     ramValid,
  input  logic                     ramWrite,
  input  logic [ramIndexWidth-1:0] ramIndex,
  input  logic [dataWidth-1:0]     ramWdata,
  input  logic [strbWidth-1:0]     ramWstrb,
  output logic [dataWidth-1:0]     ramRdata,
  output logic                     ramReady
);

  logic [dataWidth-1:0] mem [ramWords];

  // Read returns the stored word; on a write that is the old one
  always_ff @(posedge clock) begin
    if (ramValid) begin
      ramRdata <= mem[ramIndex];
      if (ramWrite) begin
        for (int b = 0; b < strbWidth; b++) begin
          if (ramWstrb[b]) begin
            mem[ramIndex][8*b +: 8] <= ramWdata[8*b +: 8];  // Strobed byte only
          end
        end
      end
    end
  end

  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      ramReady <= 1'b0;
    end else begin
      ramReady <= ramValid;
    end
  end

endmodule

/* rtl/memDecoder.sv */
`timescale 1ns/1ps

module memDecoder
  import memPkg::*;
(
  input  logic                     clock,
  input  logic                     arstN,
  // Core side
  input  logic                     memValid,
  input  memOp_e                   memOp,
  input  logic [addrWidth-1:0]     memAddr,
  input  logic [dataWidth-1:0]     memWdata,
  input  logic [strbWidth-1:0]     memWstrb,
  output logic                     memReady,
  output logic [dataWidth-1:0]     memRdata,
  output logic                     memError,
  // Boot ROM
  output logic                     romValid,
  output logic [romIndexWidth-1:0] romIndex,
  input  logic [dataWidth-1:0]     romRdata,
  input  logic                     romReady,
  // Scratch RAM
  output logic                     ramValid,
  output logic                     ramWrite,
  output logic [ramIndexWidth-1:0] ramIndex,
  output logic [dataWidth-1:0]     ramWdata,
  output logic [strbWidth-1:0]     ramWstrb,
  input  logic [dataWidth-1:0]     ramRdata,
  input  logic                     ramReady
);

  memRegion_e region;
  memRegion_e pendRegion;
  logic       romWriteHit;
  logic       errNext;
  logic       errQ;

  // Window match on the bits above each region
  always_comb begin
    if (memAddr[addrWidth-1:romAddrLsb] == romBase[addrWidth-1:romAddrLsb]) begin
      region = regionRom;
    end else if (memAddr[addrWidth-1:ramAddrLsb] == ramBase[addrWidth-1:ramAddrLsb]) begin
      region = regionRam;
    end else begin
      region = regionNone;
    end
  end

  assign romWriteHit = (region == regionRom) && (memOp == opWrite);  // ROM is read only
  assign errNext     = memValid && ((region == regionNone) || romWriteHit);

  // Request steering
  assign romValid = memValid && (region == regionRom) && (memOp == opRead);
  assign romIndex = memAddr[romAddrLsb-1:2];

  assign ramValid = memValid && (region == regionRam);
  assign ramWrite = (memOp == opWrite);
  assign ramIndex = memAddr[ramAddrLsb-1:2];
  assign ramWdata = memWdata;
  assign ramWstrb = memWstrb;

  // Region of the access in flight and locally generated error
  always_ff @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pendRegion <= regionNone;
      errQ       <= 1'b0;
    end else begin
      errQ <= errNext;
      if (memValid) begin
        pendRegion <= region;
      end
    end
  end

  // Response mux, error wins over a stale region
  always_comb begin
    if (errQ) begin
      memRdata = '0;
    end else begin
      case (pendRegion)
        regionRom: memRdata = romRdata;
        regionRam: memRdata = ramRdata;
        default:   memRdata = '0;
      endcase
    end
  end

  assign memError = errQ;
  assign memReady = errQ | romReady | ramReady;  // At most one is high

endmodule

/* rtl/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem
  import memPkg::*;
(
  input  logic                 clock,
  input  logic                 arstN,
  input  logic                 memValid,
  input  memOp_e               memOp,
  input  logic [addrWidth-1:0] memAddr,
  input  logic [dataWidth-1:0] memWdata,
  input  logic [strbWidth-1:0] memWstrb,
  output logic                 memReady,
  output logic [dataWidth-1:0] memRdata,
  output logic                 memError
);

  logic                     romValid;
  logic [romIndexWidth-1:0] romIndex;
  logic [dataWidth-1:0]     romRdata;
  logic                     romReady;

  logic                     ramValid;
  logic                     ramWrite;
  logic [ramIndexWidth-1:0] ramIndex;
  logic [dataWidth-1:0]     ramWdata;
  logic [strbWidth-1:0]     ramWstrb;
  logic [dataWidth-1:0]     ramRdata;
  logic                     ramReady;

  memDecoder u_memDecoder (
    .clock    (clock),
    .arstN    (arstN),
    .memValid (memValid),
    .memOp    (memOp),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memWstrb (memWstrb),
    .memReady (memReady),
    .memRdata (memRdata),
    .memError (memError),
    .romValid (romValid),
    .romIndex (romIndex),
    .romRdata (romRdata),
    .romReady (romReady),
    .ramValid (ramValid),
    .ramWrite (ramWrite),
    .ramIndex (ramIndex),
    .ramWdata (ramWdata),
    .ramWstrb (ramWstrb),
    .ramRdata (ramRdata),
    .ramReady (ramReady)
  );

  bootRom u_bootRom (
    .clock    (clock),
    .arstN    (arstN),
    .romValid (romValid),
    .romIndex (romIndex),
    .romRdata (romRdata),
    .romReady (romReady)
  );

  scratchRam u_scratchRam (
    .clock    (clock),
    .arstN    (arstN),
    .ramValid (ramValid),
    .ramWrite (ramWrite),
    .ramIndex (ramIndex),
    .ramWdata (ramWdata),
    .ramWstrb (ramWstrb),
    .ramRdata (ramRdata),
    .ramReady (ramReady)
  );

endmodule

/* tb/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb
  import memPkg::*;
();

  localparam int clockPeriod = 100;
  localparam int resetCycles = 16;
  localparam int ramPairs    = 64;
  localparam int randomCount = 300;
  // Worst case per phase: reset, quiet bus, ROM sweep, RAM fill, RAM pairs,
  // unmapped, ROM writes, random traffic with gaps, drain
  localparam int stimulusCycles = resetCycles + 4 + (romWords + 1) + (ramWords + 1)
                                + (2 * ramPairs + 1) + 17 + 7 + 2 * randomCount + 3;
  localparam int timeoutCycles  = 2 * stimulusCycles + 100;

  localparam logic [31:0] unmappedAddr [8] = '{
    32'h0000_0100, 32'h0000_4000, 32'h0000_FFFC, 32'h0001_0400,
    32'h0002_0000, 32'h1000_0010, 32'h8000_0000, 32'hFFFF_FFFC
  };
  localparam int romProbe [3] = '{0, 15, 38};

  logic                 clock;
  logic                 arstN;
  logic                 memValid;
  memOp_e               memOp;
  logic [addrWidth-1:0] memAddr;
  logic [dataWidth-1:0] memWdata;
  logic [strbWidth-1:0] memWstrb;
  logic                 memReady;
  logic [dataWidth-1:0] memRdata;
  logic                 memError;

  // Expected record of the request on the bus, then of the one completing
  logic        issValid;
  logic [31:0] issRdata;
  logic        issError;
  logic        issCheck;
  logic        pendValid;
  logic [31:0] pendRdata;
  logic        pendError;
  logic        pendCheck;

  logic [31:0] shadow [ramWords];
  bit          shadowKnown [ramWords];  // Set once all four bytes are written
  logic [31:0] lfsrState = 32'haceb;
  int          errorCount = 0;
  int          reqCount = 0;
  int          respCount = 0;
  int          cycleCount = 0;

  memSubsystem u_memSubsystem (
    .clock    (clock),
    .arstN    (arstN),
    .memValid (memValid),
    .memOp    (memOp),
    .memAddr  (memAddr),
    .memWdata (memWdata),
    .memWstrb (memWstrb),
    .memReady (memReady),
    .memRdata (memRdata),
    .memError (memError)
  );

  initial begin
    clock = 1'b0;
    forever #(clockPeriod / 2) clock = ~clock;
  end

  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
    end
    return next;
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      result = {result[30:0], lfsrState[0]};
    end
    return result;
  endfunction

  function automatic logic inRom(input logic [31:0] addr);
    return (addr - romBase) < 32'(4 * romWords);
  endfunction

  function automatic logic inRam(input logic [31:0] addr);
    return (addr - ramBase) < 32'(4 * ramWords);
  endfunction

  // Only these ROM words are pinned down; 39 and up are blank
  function automatic logic romKnown(input int index);
    return (index == 0) || (index == 15) || (index == 16) || (index >= 38);
  endfunction

  function automatic logic [31:0] romWord(input int index);
    case (index)
      0:       return 32'h41014081;
      15:      return 32'h62F94F81;
      16:      return 32'h60028293;
      38:      return 32'h80678000;
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] fillWord(input logic [31:0] addr);
    return {addr[7:0], addr[15:8], addr[23:16], addr[31:24]} ^ 32'h5A5A_A5A5;
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    errorCount++;
    $display("Fail %s: got %h expected %h at %0t", name, got, expected, $time);
  endtask

  // Model the access, then put it on the bus for one cycle
  task automatic access(input memOp_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] wstrb);
    int          index;
    logic [31:0] expData;
    logic        expErr;
    logic        check;
    expData = '0;
    expErr  = 1'b0;
    check   = 1'b1;
    if (inRom(addr)) begin
      index = int'((addr - romBase) >> 2);
      if (op == opWrite) begin
        expErr = 1'b1;  // ROM is read only
      end else begin
        check   = romKnown(index);
        expData = romWord(index);
      end
    end else if (inRam(addr)) begin
      index   = int'((addr - ramBase) >> 2);
      expData = shadow[index];  // Old word, also on a write
      check   = shadowKnown[index];
      if (op == opWrite) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) begin
            shadow[index][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        if (wstrb == 4'hF) begin
          shadowKnown[index] = 1'b1;
        end
      end
    end else begin
      expErr = 1'b1;
    end
    @(posedge clock);
    #1;
    memValid = 1'b1;
    memOp    = op;
    memAddr  = addr;
    memWdata = wdata;
    memWstrb = wstrb;
    issValid = 1'b1;
    issRdata = expData;
    issError = expErr;
    issCheck = check;
    reqCount++;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clock);
      #1;
      memValid = 1'b0;
      issValid = 1'b0;
      issCheck = 1'b0;
    end
  endtask

  always @(posedge clock or negedge arstN) begin
    if (!arstN) begin
      pendValid <= 1'b0;
      pendRdata <= '0;
      pendError <= 1'b0;
      pendCheck <= 1'b0;
    end else begin
      pendValid <= issValid;
      pendRdata <= issRdata;
      pendError <= issError;
      pendCheck <= issCheck;
    end
  end

  readyFollowsRequest: assert property (
    @(posedge clock) disable iff (!arstN) memReady == pendValid
  ) else reportMismatch("memReady", 32'($sampled(memReady)), 32'($sampled(pendValid)));

  errorMatches: assert property (
    @(posedge clock) disable iff (!arstN) memError == (pendValid && pendError)
  ) else reportMismatch("memError", 32'($sampled(memError)),
                        32'($sampled(pendValid && pendError)));

  rdataMatches: assert property (
    @(posedge clock) disable iff (!arstN) pendValid && pendCheck |-> memRdata == pendRdata
  ) else reportMismatch("memRdata", $sampled(memRdata), $sampled(pendRdata));

  always @(posedge clock) begin
    if (memReady) begin
      respCount <= respCount + 1;
    end
  end

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == timeoutCycles) begin
      $display("Timeout: stimulus still running after %0d cycles", cycleCount);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    memOp_e      op;
    int          countErrors;
    arstN    = 1'b0;
    memValid = 1'b0;
    memOp    = opRead;
    memAddr  = '0;
    memWdata = '0;
    memWstrb = '0;
    issValid = 1'b0;
    issRdata = '0;
    issError = 1'b0;
    issCheck = 1'b0;
    countErrors = 0;
    repeat (resetCycles) @(posedge clock);
    #1;
    arstN = 1'b1;
    idle(4);  // Quiet bus

    for (int w = 0; w < romWords; w++) begin
      access(opRead, romBase + 32'(4 * w), '0, '0);
    end
    idle(1);

    for (int w = 0; w < ramWords; w++) begin
      addr = ramBase + 32'(4 * w);
      access(opWrite, addr, fillWord(addr), 4'hF);
    end
    idle(1);

    // Random partial write, then read back next cycle
    for (int i = 0; i < ramPairs; i++) begin
      addr = ramBase + (takeBits(8) << 2);
      data = takeBits(32);
      rnd  = takeBits(4);
      access(opWrite, addr, data, rnd[3:0]);
      access(opRead, addr, '0, '0);
    end
    idle(1);

    foreach (unmappedAddr[i]) begin
      access(opRead, unmappedAddr[i], '0, '0);
      access(opWrite, unmappedAddr[i], takeBits(32), 4'hF);
    end
    idle(1);

    foreach (romProbe[i]) begin
      addr = romBase + 32'(4 * romProbe[i]);
      access(opWrite, addr, takeBits(32), 4'hF);
      access(opRead, addr, '0, '0);
    end
    idle(1);

    for (int i = 0; i < randomCount; i++) begin
      rnd = takeBits(2);
      case (rnd[1:0])
        2'd0:    addr = romBase + (takeBits(6) << 2);
        2'd2:    addr = takeBits(32) & 32'hFFFF_FFFC;
        default: addr = ramBase + (takeBits(8) << 2);
      endcase
      rnd  = takeBits(1);
      op   = rnd[0] ? opWrite : opRead;
      data = takeBits(32);
      rnd  = takeBits(4);
      strb = rnd[3:0];
      access(op, addr, data, strb);
      rnd = takeBits(1);
      if (rnd[0]) begin
        idle(1);
      end
    end
    idle(3);  // Let the last completion land

    if (respCount != reqCount) begin
      countErrors = 1;
      $display("Response count %0d does not match request count %0d", respCount, reqCount);
    end
    $display("Requests %0d, responses %0d, errors %0d",
             reqCount, respCount, errorCount + countErrors);
    if (errorCount + countErrors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
rtl/memPkg.sv
rtl/bootRom.sv
rtl/scratchRam.sv
rtl/memDecoder.sv
rtl/memSubsystem.sv
tb/memSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator; the printed result line decides the exit status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module memSubsystemTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Result: PASSED" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: build or simulation failed" >&2; exit 1; }
